//--- project.f
common/adma_pkg.sv
adma/adma_regs.sv
adma/adma_fsm.sv
adma/desc_fetch.sv
adma/data_mover.sv
logic/ram_arbiter.sv
logic/adma_top.sv
testbench/adma_checker.sv
testbench/tb_adma.sv

//--- run.sh
#!/bin/bash
# build and run the adma testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_adma -f project.f -o sim_adma || exit 1
out="$(./obj_dir/sim_adma)"
echo "$out"
echo "$out" | grep -qx "TEST PASSED" && exit 0 || exit 1

//--- testbench/tb_adma.sv
`timescale 1ns/1ps
/*
 * adma testbench
 * apb driver, ram and fifo models, reference walker and test sequence
 */
module tb_adma import adma_pkg::*;;
   logic        CLK = 1'b0;
   logic        RESET;
   logic [7:0]  paddr;
   logic        psel, penable, pwrite;
   logic [31:0] pwdata, prdata;
   logic        pready, pslverr;
   logic [31:0] ram_addr, ram_wdata;
   logic [31:0] ram_rdata = '0;
   logic        ram_read, ram_write;
   logic        fifo_write, fifo_read, irq;
   logic [31:0] fifo_wdata;
   logic [31:0] fifo_rdata = '0;
   logic        fifo_full  = 1'b0;
   logic        fifo_empty = 1'b1;

   logic [31:0] mem [0:1023];       // ram seen by the dut
   logic [31:0] ref_mem [0:1023];   // reference copy
   logic [31:0] exp_words [0:255];  // expected fifo stream, whole run
   logic [31:0] src_words [0:15];   // fifo prefill
   int          exp_total, exp_count, src_idx, tb_errors, chk_errors, fifo_seen;
   logic        exp_irq, exp_err, timed_out;
   logic [31:0] ref_ptr, rnd_data, rnd_bp, status;
   logic        host_we, fifo_load, bp_en;
   logic [31:0] host_addr, host_data;
   logic [4:0]  rd_ptr, avail, fifo_load_n;

   always #10 CLK = ~CLK;

   adma_top #(.addr_width(32), .len_width(16)) i_dut (
      .CLK(CLK), .RESET(RESET), .paddr(paddr), .psel(psel), .penable(penable),
      .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
      .pslverr(pslverr), .ram_addr(ram_addr), .ram_read(ram_read),
      .ram_write(ram_write), .ram_wdata(ram_wdata), .ram_rdata(ram_rdata),
      .fifo_write(fifo_write), .fifo_wdata(fifo_wdata), .fifo_full(fifo_full),
      .fifo_read(fifo_read), .fifo_rdata(fifo_rdata), .fifo_empty(fifo_empty), .irq(irq)
   );

   adma_checker #(.cycle_limit(20000)) i_chk (
      .CLK(CLK), .RESET(RESET), .fifo_write(fifo_write), .fifo_wdata(fifo_wdata),
      .exp_words(exp_words), .exp_total(exp_total), .fifo_seen(fifo_seen),
      .errors(chk_errors), .timed_out(timed_out)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic logic [31:0] fill_word(input logic [9:0] a);
      return {a, 6'h2b, ~a, 6'h14};   // every address bit shows
   endfunction

   function automatic logic [31:0] dw0(input logic [15:0] len, input logic [1:0] act,
                                      input logic e, input logic it);
      return {len, 10'd0, act, 1'b0, it, e, 1'b1};
   endfunction

   ////////////////////
   // ram and fifo
   ////////////////////
   always @(posedge CLK) begin
      if (RESET) begin
         for (int i = 0; i < 1024; i++)
            mem[i] <= fill_word(10'(i));
      end else begin
         if (host_we)
            mem[host_addr[11:2]] <= host_data;   // table setup
         else if (ram_write)
            mem[ram_addr[11:2]] <= ram_wdata;
         if (ram_read)
            ram_rdata <= mem[ram_addr[11:2]];
      end
   end

   always @(posedge CLK) begin : fifo_model
      logic [4:0] nxt;
      if (RESET) begin
         rnd_bp     <= 32'd5698;
         rd_ptr     <= '0;
         avail      <= '0;
         fifo_full  <= 1'b0;
         fifo_empty <= 1'b1;
      end else begin
         rnd_bp    <= lcg_next(rnd_bp);
         fifo_full <= bp_en & (rnd_bp[17:16] == 2'b00);
         nxt = rd_ptr + (fifo_read ? 5'd1 : 5'd0);
         if (fifo_read)
            fifo_rdata <= src_words[rd_ptr[3:0]];
         if (fifo_load) begin
            rd_ptr     <= '0;
            avail      <= fifo_load_n;
            fifo_empty <= (fifo_load_n == 5'd0);
         end else begin
            rd_ptr     <= nxt;
            fifo_empty <= (nxt >= avail) | (bp_en & (rnd_bp[19:18] == 2'b00));
         end
      end
   end

   ////////////////////
   // reference walker
   ////////////////////
   function automatic void ref_walk(input logic [31:0] start, input logic dir, input int max_desc);
      logic [31:0] w0, w1;
      logic [1:0]  act;
      int          n;
      bit          done;
      ref_ptr = start;
      n = 0;
      done = 0;
      while (!done) begin
         w0 = ref_mem[ref_ptr[11:2]];
         w1 = ref_mem[ref_ptr[11:2] + 10'd1];
         if (!w0[desc_valid_bit]) begin
            exp_err = 1'b1;   // pointer stays on the bad entry
            done = 1;
         end else begin
            act = w0[desc_act_msb:desc_act_lsb];
            if (act == act_tran) begin
               for (int i = 0; i < int'(w0[desc_len_msb:desc_len_lsb]); i++) begin
                  if (dir) begin
                     exp_words[exp_total] = ref_mem[w1[11:2] + 10'(i)];
                     exp_total++;
                  end else begin
                     ref_mem[w1[11:2] + 10'(i)] = src_words[src_idx];
                     src_idx++;
                  end
               end
               exp_count++;
            end
            if (w0[desc_int_bit])
               exp_irq = 1'b1;
            ref_ptr = (act == act_link) ? w1 : ref_ptr + 32'd8;
            n++;
            done = w0[desc_end_bit] || (n == max_desc);
         end
      end
   endfunction

   function automatic void check_val(input string what, input logic [31:0] got,
                                     input logic [31:0] exp);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
         tb_errors++;
      end
   endfunction

   task automatic apb_write(input logic [7:0] a, input logic [31:0] d);
      @(posedge CLK);
      paddr   <= a;
      pwdata  <= d;
      pwrite  <= 1'b1;
      psel    <= 1'b1;
      penable <= 1'b0;
      @(posedge CLK);
      penable <= 1'b1;
      @(posedge CLK);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] a, output logic [31:0] d, output logic e);
      @(posedge CLK);
      paddr   <= a;
      pwrite  <= 1'b0;
      psel    <= 1'b1;
      penable <= 1'b0;
      @(posedge CLK);
      penable <= 1'b1;
      @(negedge CLK);   // access phase, stable
      d = prdata;
      e = pslverr;
      check_val("pready in access phase", {31'd0, pready}, 32'd1);
      @(posedge CLK);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic put_desc(input logic [31:0] a, input logic [31:0] w0, input logic [31:0] w1);
      for (int i = 0; i < 2; i++) begin
         @(posedge CLK);
         host_we   <= 1'b1;
         host_addr <= a + 32'(4 * i);
         host_data <= (i == 0) ? w0 : w1;
         ref_mem[a[11:2] + 10'(i)] = (i == 0) ? w0 : w1;
      end
      @(posedge CLK);
      host_we <= 1'b0;
   endtask

   task automatic fill_fifo(input int n);
      for (int i = 0; i < n; i++) begin
         rnd_data = lcg_next(rnd_data);
         src_words[i] = rnd_data;
      end
      src_idx = 0;
      @(posedge CLK);
      fifo_load <= 1'b1;
      fifo_load_n <= 5'(n);
      @(posedge CLK);
      fifo_load <= 1'b0;
   endtask

   task automatic start_walk(input logic [31:0] a, input logic dir, input int max_desc);
      exp_count = 0;
      ref_walk(a, dir, max_desc);
      apb_write(reg_addr, a);
      apb_write(reg_ctrl, {29'd0, dir, 2'b01});
   endtask

   // poll until idle, then compare registers, ram and fifo stream
   task automatic finish_check();
      logic e;
      do
         apb_read(reg_status, status, e);
      while (status[2:0] != 3'd0);
      check_val("state and busy", {28'd0, status[3:0]}, 32'd0);
      check_val("error flag", {31'd0, status[4]}, {31'd0, exp_err});
      check_val("irq flag", {31'd0, status[8]}, {31'd0, exp_irq});
      check_val("irq pin", {31'd0, irq}, {31'd0, exp_irq});
      apb_read(reg_count, status, e);
      check_val("descriptor count", status, 32'(exp_count));
      for (int i = 0; i < 1024; i++)
         check_val($sformatf("ram word %0d", i), mem[i], ref_mem[i]);
      check_val("fifo words seen", 32'(fifo_seen), 32'(exp_total));
   endtask

   task automatic ram_to_fifo_chain();
      put_desc(32'h100, dw0(16'd4, act_tran, 1'b0, 1'b0), 32'h800);
      put_desc(32'h108, dw0(16'd3, act_tran, 1'b0, 1'b0), 32'h900);
      put_desc(32'h110, dw0(16'd5, act_tran, 1'b1, 1'b0), 32'hA00);
      start_walk(32'h100, 1'b1, 0);
      finish_check();
   endtask

   task automatic fifo_to_ram_chain();
      fill_fifo(12);
      put_desc(32'h400, dw0(16'd5, act_tran, 1'b0, 1'b0), 32'hC00);
      put_desc(32'h408, dw0(16'd7, act_tran, 1'b1, 1'b0), 32'hD00);
      start_walk(32'h400, 1'b0, 0);
      finish_check();
   endtask

   initial begin
      logic e;
      RESET       <= 1'b1;
      paddr       <= '0;
      psel        <= 1'b0;
      penable     <= 1'b0;
      pwrite      <= 1'b0;
      pwdata      <= '0;
      host_we     <= 1'b0;
      host_addr   <= '0;
      host_data   <= '0;
      fifo_load   <= 1'b0;
      fifo_load_n <= '0;
      bp_en       <= 1'b0;
      exp_total = 0;
      tb_errors = 0;
      exp_irq   = 1'b0;
      exp_err   = 1'b0;
      rnd_data  = 32'd5698;
      for (int i = 0; i < 1024; i++)
         ref_mem[i] = fill_word(10'(i));
      repeat (16) @(posedge CLK);
      RESET <= 1'b0;

      ram_to_fifo_chain();
      // link to a second table past nop and rsv
      put_desc(32'h200, dw0(16'd3, act_nop, 1'b0, 1'b0), 32'h0);
      put_desc(32'h208, dw0(16'd2, act_rsv, 1'b0, 1'b0), 32'h0);
      put_desc(32'h210, dw0(16'd0, act_link, 1'b0, 1'b0), 32'h300);
      put_desc(32'h300, dw0(16'd2, act_tran, 1'b1, 1'b0), 32'hB00);
      start_walk(32'h200, 1'b1, 0);
      finish_check();
      fifo_to_ram_chain();
      bp_en <= 1'b1;   // random full and empty
      ram_to_fifo_chain();
      fifo_to_ram_chain();
      bp_en <= 1'b0;

      // int, then a bad entry, then continue after the fix
      put_desc(32'h500, dw0(16'd2, act_tran, 1'b0, 1'b1), 32'hB40);
      put_desc(32'h508, 32'h0, 32'h0);
      put_desc(32'h510, dw0(16'd1, act_tran, 1'b1, 1'b0), 32'hB80);
      start_walk(32'h500, 1'b1, 0);
      finish_check();
      apb_write(reg_status, 32'h100);
      exp_irq = 1'b0;
      exp_err = 1'b0;
      apb_read(reg_status, status, e);
      check_val("status after clear", status & 32'h110, 32'h0);
      put_desc(32'h508, dw0(16'd0, act_nop, 1'b0, 1'b0), 32'h0);
      ref_walk(ref_ptr, 1'b1, 0);
      apb_write(reg_ctrl, 32'h6);
      finish_check();

      // stop lands during the first descriptor
      put_desc(32'h600, dw0(16'd8, act_tran, 1'b0, 1'b0), 32'h800);
      put_desc(32'h608, dw0(16'd4, act_tran, 1'b1, 1'b0), 32'h900);
      start_walk(32'h600, 1'b1, 1);
      apb_write(reg_ctrl, 32'hC);
      finish_check();
      apb_read(8'h10, status, e);
      check_val("pslverr on unmapped offset", {31'd0, e}, 32'd1);

      $display("errors: %0d fifo or timeout, %0d register or ram", chk_errors, tb_errors);
      if (chk_errors + tb_errors == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

   always @(posedge CLK) begin
      if (timed_out) begin
         $display("errors: %0d fifo or timeout, %0d register or ram", chk_errors, tb_errors);
         $display("TEST FAILED");
         $finish;
      end
   end

endmodule

//--- testbench/adma_checker.sv
`timescale 1ns/1ps
/*
 * adma checker
 * compares fifo writes against the expected stream and limits the run
 */
module adma_checker #(
   parameter int cycle_limit = 20000
) (
   input  logic        CLK,
   input  logic        RESET,
   input  logic        fifo_write,
   input  logic [31:0] fifo_wdata,
   input  logic [31:0] exp_words [0:255],
   input  int          exp_total,
   output int          fifo_seen,
   output int          errors,
   output logic        timed_out
);
   int cycles;

   always @(posedge CLK) begin : watch
      int e;
      if (RESET) begin
         cycles    <= 0;
         fifo_seen <= 0;
         errors    <= 0;
         timed_out <= 1'b0;
      end else begin
         e = errors;
         cycles <= cycles + 1;
         if ((cycles == cycle_limit) && !timed_out) begin
            $display("timeout: the walk did not return to stop within %0d cycles",
                     cycle_limit);
            timed_out <= 1'b1;
            e++;
         end
         if (fifo_write) begin
            if (fifo_seen >= exp_total) begin
               $display("fifo received an extra word %h at %0t", fifo_wdata, $time);
               e++;
            end else if (fifo_wdata !== exp_words[fifo_seen]) begin
               $display("mismatch at %0t: fifo word %0d got %h expected %h",
                        $time, fifo_seen, fifo_wdata, exp_words[fifo_seen]);
               e++;
            end
            fifo_seen <= fifo_seen + 1;   // stream index, whole run
         end
         errors <= e;
      end
   end

endmodule

//--- logic/adma_top.sv
`timescale 1ns/1ps
/*
 * adma top level
 * register block, walker, fetcher, mover and ram arbiter
 */
module adma_top import adma_pkg::*; #(
   parameter int addr_width = 32,
   parameter int len_width  = 16
) (
   input  logic                  CLK,
   input  logic                  RESET,
   input  logic [7:0]            paddr,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [31:0]           pwdata,
   output logic [31:0]           prdata,
   output logic                  pready,
   output logic                  pslverr,
   output logic [addr_width-1:0] ram_addr,
   output logic                  ram_read,
   output logic                  ram_write,
   output logic [31:0]           ram_wdata,
   input  logic [31:0]           ram_rdata,
   output logic                  fifo_write,
   output logic [31:0]           fifo_wdata,
   input  logic                  fifo_full,
   output logic                  fifo_read,
   input  logic [31:0]           fifo_rdata,
   input  logic                  fifo_empty,
   output logic                  irq
);
   adma_state_t           state;
   desc_action_t          desc_action;
   logic                  cmd_start, cmd_continue, cmd_stop, direction;
   logic [addr_width-1:0] start_addr, fetch_addr, xfer_addr, desc_addr;
   logic [len_width-1:0]  desc_length, xfer_length;
   logic                  desc_done, desc_int_pulse, desc_error;
   logic                  fetch_start, fetch_done, xfer_start, xfer_done;
   logic                  desc_valid, desc_end, desc_int;
   logic                  f_req_read, f_gnt, f_rvalid;
   logic [addr_width-1:0] f_addr, m_addr;
   logic                  m_req_read, m_req_write, m_gnt, m_rvalid;
   logic [31:0]           m_wdata, rdata;

   adma_regs #(.addr_width(addr_width)) i_regs (
      .CLK(CLK), .RESET(RESET),
      .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
      .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
      .state(state), .desc_done(desc_done), .desc_int(desc_int_pulse),
      .desc_error(desc_error), .cmd_start(cmd_start), .cmd_continue(cmd_continue),
      .cmd_stop(cmd_stop), .start_addr(start_addr), .direction(direction), .irq(irq)
   );

   adma_fsm #(.addr_width(addr_width), .len_width(len_width)) i_fsm (
      .CLK(CLK), .RESET(RESET),
      .cmd_start(cmd_start), .cmd_continue(cmd_continue), .cmd_stop(cmd_stop),
      .start_addr(start_addr), .fetch_done(fetch_done), .desc_valid(desc_valid),
      .desc_end(desc_end), .desc_int(desc_int), .desc_action(desc_action),
      .desc_length(desc_length), .desc_addr(desc_addr), .xfer_done(xfer_done),
      .state(state), .fetch_start(fetch_start), .fetch_addr(fetch_addr),
      .xfer_start(xfer_start), .xfer_addr(xfer_addr), .xfer_length(xfer_length),
      .desc_done(desc_done), .desc_int_pulse(desc_int_pulse), .desc_error(desc_error)
   );

   desc_fetch #(.addr_width(addr_width), .len_width(len_width)) i_fetch (
      .CLK(CLK), .RESET(RESET),
      .fetch_start(fetch_start), .fetch_addr(fetch_addr),
      .gnt(f_gnt), .rdata(rdata), .rvalid(f_rvalid),
      .req_read(f_req_read), .req_addr(f_addr), .fetch_done(fetch_done),
      .desc_valid(desc_valid), .desc_end(desc_end), .desc_int(desc_int),
      .desc_action(desc_action), .desc_length(desc_length), .desc_addr(desc_addr)
   );

   data_mover #(.addr_width(addr_width), .len_width(len_width)) i_mover (
      .CLK(CLK), .RESET(RESET),
      .xfer_start(xfer_start), .xfer_addr(xfer_addr), .xfer_length(xfer_length),
      .direction(direction), .gnt(m_gnt), .rdata(rdata), .rvalid(m_rvalid),
      .fifo_full(fifo_full), .fifo_empty(fifo_empty), .fifo_rdata(fifo_rdata),
      .req_read(m_req_read), .req_write(m_req_write), .req_addr(m_addr),
      .req_wdata(m_wdata), .fifo_write(fifo_write), .fifo_wdata(fifo_wdata),
      .fifo_read(fifo_read), .xfer_done(xfer_done)
   );

   ram_arbiter #(.addr_width(addr_width)) i_arb (
      .CLK(CLK), .RESET(RESET),
      .f_req_read(f_req_read), .f_addr(f_addr),
      .m_req_read(m_req_read), .m_req_write(m_req_write), .m_addr(m_addr),
      .m_wdata(m_wdata), .ram_rdata(ram_rdata),
      .f_gnt(f_gnt), .m_gnt(m_gnt), .f_rvalid(f_rvalid), .m_rvalid(m_rvalid),
      .rdata(rdata), .ram_addr(ram_addr), .ram_read(ram_read),
      .ram_write(ram_write), .ram_wdata(ram_wdata)
   );

endmodule

//--- logic/ram_arbiter.sv
`timescale 1ns/1ps
/*
 * ram port arbiter
 * fixed priority to the fetcher, read data steered back to its owner
 */
module ram_arbiter #(
   parameter int addr_width = 32
) (
   input  logic                  CLK,
   input  logic                  RESET,
   input  logic                  f_req_read,
   input  logic [addr_width-1:0] f_addr,
   input  logic                  m_req_read,
   input  logic                  m_req_write,
   input  logic [addr_width-1:0] m_addr,
   input  logic [31:0]           m_wdata,
   input  logic [31:0]           ram_rdata,
   output logic                  f_gnt,
   output logic                  m_gnt,
   output logic                  f_rvalid,
   output logic                  m_rvalid,
   output logic [31:0]           rdata,
   output logic [addr_width-1:0] ram_addr,
   output logic                  ram_read,
   output logic                  ram_write,
   output logic [31:0]           ram_wdata
);
   assign f_gnt     = f_req_read;
   assign m_gnt     = (m_req_read | m_req_write) & ~f_req_read;
   assign ram_read  = f_gnt | (m_gnt & m_req_read);
   assign ram_write = m_gnt & m_req_write;
   assign ram_addr  = f_gnt ? f_addr : m_addr;
   assign ram_wdata = m_wdata;
   assign rdata     = ram_rdata;

   // owner of the read in flight
   always_ff @(posedge CLK) begin
      if (RESET) begin
         f_rvalid <= 1'b0;
         m_rvalid <= 1'b0;
      end else begin
         f_rvalid <= f_gnt;
         m_rvalid <= m_gnt & m_req_read;
      end
   end

endmodule

//--- adma/data_mover.sv
`timescale 1ns/1ps
/*
 * data mover
 * copies a run of 32-bit words between ram and the data fifo,
 * one word in flight, stalling on fifo full or empty
 */
module data_mover #(
   parameter int addr_width = 32,
   parameter int len_width  = 16
) (
   input  logic                  CLK,
   input  logic                  RESET,
   input  logic                  xfer_start,
   input  logic [addr_width-1:0] xfer_addr,
   input  logic [len_width-1:0]  xfer_length,
   input  logic                  direction,
   input  logic                  gnt,
   input  logic [31:0]           rdata,
   input  logic                  rvalid,
   input  logic                  fifo_full,
   input  logic                  fifo_empty,
   input  logic [31:0]           fifo_rdata,
   output logic                  req_read,
   output logic                  req_write,
   output logic [addr_width-1:0] req_addr,
   output logic [31:0]           req_wdata,
   output logic                  fifo_write,
   output logic [31:0]           fifo_wdata,
   output logic                  fifo_read,
   output logic                  xfer_done
);
   typedef enum logic [2:0] {
      m_idle, m_ram_rd, m_ram_wait, m_fifo_wr, m_fifo_rd, m_fifo_wait, m_ram_wr
   } mover_state_t;

   mover_state_t          mstate;
   logic [addr_width-1:0] addr;
   logic [len_width-1:0]  remain;
   logic                  to_fifo;
   logic [31:0]           word;
   logic                  step;   // word retired this cycle
   logic                  last;

   assign req_read   = (mstate == m_ram_rd);
   assign req_write  = (mstate == m_ram_wr);
   assign req_addr   = addr;
   assign req_wdata  = word;
   assign fifo_write = (mstate == m_fifo_wr) & ~fifo_full;
   assign fifo_wdata = word;
   assign fifo_read  = (mstate == m_fifo_rd) & ~fifo_empty;
   assign step       = fifo_write | ((mstate == m_ram_wr) & gnt);
   assign last       = (remain == len_width'(1));

   always_ff @(posedge CLK) begin
      if (RESET) begin
         mstate    <= m_idle;
         remain    <= '0;
         to_fifo   <= 1'b0;
         xfer_done <= 1'b0;
      end else begin
         xfer_done <= 1'b0;
         case (mstate)
            m_idle: begin
               if (xfer_start) begin
                  to_fifo <= direction;
                  remain  <= xfer_length;
                  if (xfer_length == '0)
                     xfer_done <= 1'b1;   // empty run
                  else
                     mstate <= direction ? m_ram_rd : m_fifo_rd;
               end
            end
            m_ram_rd:    if (gnt) mstate <= m_ram_wait;
            m_ram_wait:  if (rvalid) mstate <= m_fifo_wr;
            m_fifo_rd:   if (!fifo_empty) mstate <= m_fifo_wait;
            m_fifo_wait: mstate <= m_ram_wr;
            m_fifo_wr, m_ram_wr: begin
               if (step) begin
                  remain <= remain - len_width'(1);
                  if (last) begin
                     mstate    <= m_idle;
                     xfer_done <= 1'b1;
                  end else begin
                     mstate <= to_fifo ? m_ram_rd : m_fifo_rd;
                  end
               end
            end
            default: mstate <= m_idle;
         endcase
      end
   end

   ////////////////////
   // address and word
   ////////////////////
   always_ff @(posedge CLK) begin
      if ((mstate == m_idle) && xfer_start)
         addr <= xfer_addr;
      else if (step)
         addr <= addr + addr_width'(4);
      if ((mstate == m_ram_wait) && rvalid)
         word <= rdata;
      else if (mstate == m_fifo_wait)
         word <= fifo_rdata;   // fifo data one cycle after read
   end

endmodule

//--- adma/desc_fetch.sv
`timescale 1ns/1ps
/*
 * descriptor fetcher
 * reads both descriptor words through the arbiter and decodes them
 */
module desc_fetch import adma_pkg::*; #(
   parameter int addr_width = 32,
   parameter int len_width  = 16
) (
   input  logic                  CLK,
   input  logic                  RESET,
   input  logic                  fetch_start,
   input  logic [addr_width-1:0] fetch_addr,
   input  logic                  gnt,
   input  logic [31:0]           rdata,
   input  logic                  rvalid,
   output logic                  req_read,
   output logic [addr_width-1:0] req_addr,
   output logic                  fetch_done,
   output logic                  desc_valid,
   output logic                  desc_end,
   output logic                  desc_int,
   output desc_action_t          desc_action,
   output logic [len_width-1:0]  desc_length,
   output logic [addr_width-1:0] desc_addr
);
   typedef enum logic [2:0] {f_idle, f_rd0, f_wait0, f_rd1, f_wait1} fetch_state_t;

   fetch_state_t          fstate;
   logic [addr_width-1:0] addr;
   logic [31:0]           word0;   // attributes and length
   logic [31:0]           word1;   // address

   assign req_read = (fstate == f_rd0) | (fstate == f_rd1);
   assign req_addr = addr;

   always_ff @(posedge CLK) begin
      if (RESET) begin
         fstate     <= f_idle;
         fetch_done <= 1'b0;
      end else begin
         fetch_done <= 1'b0;
         case (fstate)
            f_idle:  if (fetch_start) fstate <= f_rd0;
            f_rd0:   if (gnt) fstate <= f_wait0;
            f_wait0: if (rvalid) fstate <= f_rd1;
            f_rd1:   if (gnt) fstate <= f_wait1;
            f_wait1: begin
               if (rvalid) begin
                  fstate     <= f_idle;
                  fetch_done <= 1'b1;
               end
            end
            default: fstate <= f_idle;
         endcase
      end
   end

   always_ff @(posedge CLK) begin
      if (fetch_start)
         addr <= fetch_addr;
      else if ((fstate == f_wait0) && rvalid)
         addr <= addr + addr_width'(4);   // second word
      if ((fstate == f_wait0) && rvalid)
         word0 <= rdata;
      if ((fstate == f_wait1) && rvalid)
         word1 <= rdata;
   end

   assign desc_valid  = word0[desc_valid_bit];
   assign desc_end    = word0[desc_end_bit];
   assign desc_int    = word0[desc_int_bit];
   assign desc_action = desc_action_t'(word0[desc_act_msb:desc_act_lsb]);
   assign desc_length = word0[desc_len_lsb +: len_width];
   assign desc_addr   = word1[addr_width-1:0];

endmodule

//--- adma/adma_fsm.sv
`timescale 1ns/1ps
/*
 * adma descriptor walker
 * steps through the descriptor table, decides on each descriptor
 * and hands fetches and transfers to the fetcher and mover
 */
module adma_fsm import adma_pkg::*; #(
   parameter int addr_width = 32,
   parameter int len_width  = 16
) (
   input  logic                  CLK,
   input  logic                  RESET,
   input  logic                  cmd_start,
   input  logic                  cmd_continue,
   input  logic                  cmd_stop,
   input  logic [addr_width-1:0] start_addr,
   input  logic                  fetch_done,
   input  logic                  desc_valid,
   input  logic                  desc_end,
   input  logic                  desc_int,
   input  desc_action_t          desc_action,
   input  logic [len_width-1:0]  desc_length,
   input  logic [addr_width-1:0] desc_addr,
   input  logic                  xfer_done,
   output adma_state_t           state,
   output logic                  fetch_start,
   output logic [addr_width-1:0] fetch_addr,
   output logic                  xfer_start,
   output logic [addr_width-1:0] xfer_addr,
   output logic [len_width-1:0]  xfer_length,
   output logic                  desc_done,
   output logic                  desc_int_pulse,
   output logic                  desc_error
);
   adma_state_t           next_state;
   logic [addr_width-1:0] ptr;        // table pointer
   logic                  stop_req;   // latched stop command
   logic                  finish;

   assign fetch_start = (state == st_fds_start);
   assign fetch_addr  = ptr;
   assign xfer_start  = (state == st_tfr_start);
   assign xfer_addr   = desc_addr;
   assign xfer_length = desc_length;
   assign finish      = desc_end | stop_req;

   assign desc_done  = (state == st_tfr) & xfer_done;
   assign desc_error = (state == st_fds) & fetch_done & ~desc_valid;
   // tran reports int at the end of its data, the others in cadr
   assign desc_int_pulse = desc_int &
                           (desc_done | ((state == st_cadr) & (desc_action != act_tran)));

   ////////////////////
   // next state
   ////////////////////
   always_comb begin
      next_state = state;
      case (state)
         st_stop:
            if (cmd_start | cmd_continue)
               next_state = st_fds_start;
         st_fds_start:
            next_state = st_fds;
         st_fds:
            if (fetch_done)
               next_state = desc_valid ? st_cadr : st_stop;
         st_cadr: begin
            if (desc_action == act_tran)
               next_state = st_tfr_start;
            else if (finish)
               next_state = st_stop;
            else
               next_state = st_fds_start;
         end
         st_tfr_start:
            next_state = st_tfr;
         st_tfr:
            if (xfer_done)
               next_state = finish ? st_stop : st_fds_start;
         default:
            next_state = st_stop;
      endcase
   end

   always_ff @(posedge CLK) begin
      if (RESET) begin
         state    <= st_stop;
         ptr      <= '0;
         stop_req <= 1'b0;
      end else begin
         state <= next_state;

         if (state == st_stop)
            stop_req <= 1'b0;   // each run starts clean
         else if (cmd_stop)
            stop_req <= 1'b1;

         // continue keeps ptr, so a halted walk resumes in place
         if ((state == st_stop) && cmd_start)
            ptr <= start_addr;
         else if (state == st_cadr)
            ptr <= (desc_action == act_link) ? desc_addr : ptr + addr_width'(8);
      end
   end

endmodule

//--- adma/adma_regs.sv
`timescale 1ns/1ps
/*
 * adma register block
 * apb slave for control pulses, start address, status, sticky irq
 * and the count of completed tran descriptors
 */
module adma_regs import adma_pkg::*; #(
   parameter int addr_width = 32
) (
   input  logic                  CLK,
   input  logic                  RESET,
   input  logic [7:0]            paddr,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [31:0]           pwdata,
   output logic [31:0]           prdata,
   output logic                  pready,
   output logic                  pslverr,
   input  adma_state_t           state,
   input  logic                  desc_done,
   input  logic                  desc_int,
   input  logic                  desc_error,
   output logic                  cmd_start,
   output logic                  cmd_continue,
   output logic                  cmd_stop,
   output logic [addr_width-1:0] start_addr,
   output logic                  direction,
   output logic                  irq
);
   logic        access;
   logic        mapped;
   logic        wr_ctrl;
   logic        wr_clear;   // status write with bit 8
   logic        adma_error;
   logic [15:0] desc_count;

   assign access   = psel & penable;
   assign mapped   = (paddr == reg_ctrl) || (paddr == reg_addr) ||
                     (paddr == reg_status) || (paddr == reg_count);
   assign wr_ctrl  = access & pwrite & (paddr == reg_ctrl);
   assign wr_clear = access & pwrite & (paddr == reg_status) & pwdata[8];
   assign pready   = 1'b1;   // zero wait states
   assign pslverr  = access & ~mapped;

   always_ff @(posedge CLK) begin
      if (RESET) begin
         cmd_start    <= 1'b0;
         cmd_continue <= 1'b0;
         cmd_stop     <= 1'b0;
         start_addr   <= '0;
         direction    <= 1'b0;
         irq          <= 1'b0;
         adma_error   <= 1'b0;
         desc_count   <= '0;
      end else begin
         cmd_start    <= wr_ctrl & pwdata[0];
         cmd_continue <= wr_ctrl & pwdata[1];
         cmd_stop     <= wr_ctrl & pwdata[3];
         if (wr_ctrl)
            direction <= pwdata[2];   // 1 = ram to fifo
         if (access & pwrite & (paddr == reg_addr))
            start_addr <= pwdata[addr_width-1:0];

         // a new event wins over a clear in the same cycle
         if (desc_int)
            irq <= 1'b1;
         else if (wr_clear)
            irq <= 1'b0;
         if (desc_error)
            adma_error <= 1'b1;
         else if (wr_clear)
            adma_error <= 1'b0;

         if (cmd_start)
            desc_count <= '0;
         else if (desc_done)
            desc_count <= desc_count + 16'd1;
      end
   end

   // read mux
   always_comb begin
      prdata = '0;
      case (paddr)
         reg_ctrl:   prdata[2] = direction;
         reg_addr:   prdata[addr_width-1:0] = start_addr;
         reg_status: begin
            prdata[2:0] = state;
            prdata[3]   = (state != st_stop);   // busy
            prdata[4]   = adma_error;
            prdata[8]   = irq;
         end
         reg_count:  prdata[15:0] = desc_count;
         default:    prdata = '0;
      endcase
   end

endmodule

//--- common/adma_pkg.sv
/*
 * adma shared definitions
 * descriptor field positions, descriptor actions, walker states
 * and apb register offsets
 */
package adma_pkg;

   ////////////////////
   // descriptor word 0
   ////////////////////
   localparam int desc_valid_bit = 0;
   localparam int desc_end_bit   = 1;
   localparam int desc_int_bit   = 2;
   localparam int desc_act_lsb   = 4;
   localparam int desc_act_msb   = 5;
   localparam int desc_len_lsb   = 16;
   localparam int desc_len_msb   = 31;   // word 1 is the address

   typedef enum logic [1:0] {
      act_nop  = 2'b00,
      act_rsv  = 2'b01,   // handled as nop
      act_tran = 2'b10,
      act_link = 2'b11
   } desc_action_t;

   typedef enum logic [2:0] {
      st_stop,
      st_fds_start,
      st_fds,
      st_cadr,
      st_tfr_start,
      st_tfr
   } adma_state_t;

   ////////////////////
   // apb offsets
   ////////////////////
   localparam logic [7:0] reg_ctrl   = 8'h00;
   localparam logic [7:0] reg_addr   = 8'h04;
   localparam logic [7:0] reg_status = 8'h08;
   localparam logic [7:0] reg_count  = 8'h0C;

endpackage
